// File: bus_ctrl.sv
module bus_ctrl (
	input  logic                       clk_i,
	input  logic                       rst_n_i,
	input  soc_pkg::apb_req_t          apb_req_i,
	output soc_pkg::apb_rsp_t          apb_rsp_o,
	output soc_pkg::ram_req_t          prog_req_o,
	output soc_pkg::ram_req_t          vid_req_o,
	input  logic [soc_pkg::DATA_W-1:0] prog_rdata_i,
	input  logic [soc_pkg::DATA_W-1:0] vid_rdata_i,
	output soc_pkg::kbd_req_t          kbd_req_o,
	input  logic [soc_pkg::DATA_W-1:0] kbd_rdata_i
);
	import soc_pkg::*;

	bus_state_e        state_q;
	bus_state_e        state_d;
	region_e           region;
	logic              access;
	logic              first;	// first access cycle.
	logic              mem_hit;
	logic              pready;
	logic [DATA_W-1:0] prdata;
	ram_req_t          ram_req;

	always_comb begin
		if (apb_req_i.paddr[ADDR_W-1 -: 2] == PROG_TAG) begin
			region = REG_PROG;
		end else if (apb_req_i.paddr[ADDR_W-1 -: 4] == KBD_TAG) begin
			region = REG_KBD;
		end else if (apb_req_i.paddr[ADDR_W-1 -: 2] == VID_TAG) begin
			region = REG_VID;
		end else begin
			region = REG_NONE;
		end
	end

	assign access  = apb_req_i.psel && apb_req_i.penable;
	assign first   = (state_q == BUS_ACCESS) && access;
	assign mem_hit = (region == REG_PROG) || (region == REG_VID);

	always_comb begin
		state_d = state_q;
		pready  = 1'b0;
		case (state_q)
			BUS_IDLE: begin
				if (apb_req_i.psel && !apb_req_i.penable) begin
					state_d = BUS_ACCESS;	// setup cycle seen.
				end
			end
			BUS_ACCESS: begin
				if (!apb_req_i.psel) begin
					state_d = BUS_IDLE;
				end else if (access) begin
					if (mem_hit && !apb_req_i.pwrite) begin
						state_d = BUS_READ_WAIT;	// one wait state.
					end else begin
						pready  = 1'b1;
						state_d = BUS_IDLE;
					end
				end
			end
			BUS_READ_WAIT: begin
				pready  = 1'b1;
				state_d = BUS_IDLE;
			end
			default: state_d = BUS_IDLE;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			state_q <= BUS_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	assign ram_req = '{
		en:    first && mem_hit,
		we:    apb_req_i.pwrite,
		addr:  apb_req_i.paddr[MEM_ADDR_W-1:0],
		wdata: apb_req_i.pwdata,
		strb:  apb_req_i.pstrb
	};

	always_comb begin
		prog_req_o    = ram_req;
		prog_req_o.en = ram_req.en && (region == REG_PROG);
		vid_req_o     = ram_req;
		vid_req_o.en  = ram_req.en && (region == REG_VID);
	end

	assign kbd_req_o = '{
		rd:  first && (region == REG_KBD) && !apb_req_i.pwrite,
		sel: apb_req_i.paddr[0]
	};

	always_comb begin
		case (region)
			REG_PROG: prdata = prog_rdata_i;
			REG_VID:  prdata = vid_rdata_i;
			REG_KBD:  prdata = kbd_rdata_i;
			default:  prdata = '0;	// unmapped reads zero.
		endcase
	end

	assign apb_rsp_o = '{prdata: prdata, pready: pready};

endmodule

// File: kbd_queue.sv
module kbd_queue (
	input  logic                       clk_i,
	input  logic                       rst_n_i,
	input  logic [7:0]                 byte_i,
	input  logic                       valid_i,
	input  soc_pkg::kbd_req_t          req_i,
	output logic [soc_pkg::DATA_W-1:0] rdata_o
);
	import soc_pkg::*;

	logic [7:0]                         fifo_mem [KBD_DEPTH];
	logic [$clog2(KBD_DEPTH)-1:0]       wr_ptr;
	logic [$clog2(KBD_DEPTH)-1:0]       rd_ptr;
	logic [$clog2(KBD_DEPTH+1)-1:0]     count;
	logic                               empty;
	logic                               full;
	logic                               push;
	logic                               pop;

	assign empty = (count == '0);
	assign full  = (int'(count) == KBD_DEPTH);
	assign pop   = req_i.rd && req_i.sel && !empty;
	assign push  = valid_i && (!full || pop);	// dropped when full.

	always_ff @(posedge clk_i) begin
		if (push) begin
			fifo_mem[wr_ptr] <= byte_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_comb begin
		rdata_o = '0;
		if (req_i.sel) begin
			if (!empty) begin
				rdata_o[7:0] = fifo_mem[rd_ptr];	// oldest byte.
			end
		end else begin
			rdata_o[1:0] = {full, !empty};
		end
	end

endmodule

// File: nexys_soc.sv
module nexys_soc (
	input  logic              clk_i,
	input  logic              rst_n_i,
	input  soc_pkg::apb_req_t apb_req_i,
	output soc_pkg::apb_rsp_t apb_rsp_o,
	input  logic              ps2_clk_i,
	input  logic              ps2_dat_i
);
	import soc_pkg::*;

	ram_req_t          prog_req;
	ram_req_t          vid_req;
	kbd_req_t          kbd_req;
	logic [DATA_W-1:0] prog_rdata;
	logic [DATA_W-1:0] vid_rdata;
	logic [DATA_W-1:0] kbd_rdata;
	logic              ps2_fall;
	logic              ps2_busy;
	logic              ps2_stall;
	logic              ps2_valid;
	logic [7:0]        ps2_byte;

	bus_ctrl bus (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.apb_req_i   (apb_req_i),
		.apb_rsp_o   (apb_rsp_o),
		.prog_req_o  (prog_req),
		.vid_req_o   (vid_req),
		.prog_rdata_i(prog_rdata),
		.vid_rdata_i (vid_rdata),
		.kbd_req_o   (kbd_req),
		.kbd_rdata_i (kbd_rdata)
	);

	word_ram #(.WORDS(MEM_WORDS)) progmem (
		.clk_i  (clk_i),
		.req_i  (prog_req),
		.rdata_o(prog_rdata)
	);

	word_ram #(.WORDS(MEM_WORDS)) vidmem (
		.clk_i  (clk_i),
		.req_i  (vid_req),
		.rdata_o(vid_rdata)
	);

	ps2_receiver ps2_rx (
		.clk_i    (clk_i),
		.rst_n_i  (rst_n_i),
		.ps2_clk_i(ps2_clk_i),
		.ps2_dat_i(ps2_dat_i),
		.stall_i  (ps2_stall),
		.fall_o   (ps2_fall),
		.busy_o   (ps2_busy),
		.byte_o   (ps2_byte),
		.valid_o  (ps2_valid)
	);

	ps2_idle_timer ps2_timer (
		.clk_i  (clk_i),
		.rst_n_i(rst_n_i),
		.fall_i (ps2_fall),
		.busy_i (ps2_busy),
		.stall_o(ps2_stall)
	);

	kbd_queue kbd (
		.clk_i  (clk_i),
		.rst_n_i(rst_n_i),
		.byte_i (ps2_byte),
		.valid_i(ps2_valid),
		.req_i  (kbd_req),
		.rdata_o(kbd_rdata)
	);

endmodule

// File: nexys_soc_chk.sv
module nexys_soc_chk (
	input logic                clk_i,
	input logic                rst_n_i,
	input soc_pkg::apb_req_t   apb_req_i,
	input soc_pkg::apb_rsp_t   apb_rsp_i,
	input soc_pkg::bus_state_e state_i,
	input soc_pkg::region_e    region_i
);
	import soc_pkg::*;

	logic setup_q;	// last cycle was an apb setup cycle.
	logic access;
	logic first;
	logic mem_rd;
	logic status_rd;

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			setup_q <= 1'b0;
		end else begin
			setup_q <= apb_req_i.psel && !apb_req_i.penable;
		end
	end

	assign access    = apb_req_i.psel && apb_req_i.penable;
	assign first     = access && setup_q;	// first access cycle.
	assign mem_rd    = ((region_i == REG_PROG) || (region_i == REG_VID)) && !apb_req_i.pwrite;
	assign status_rd = access && apb_rsp_i.pready && (region_i == REG_KBD)
		&& !apb_req_i.pwrite && !apb_req_i.paddr[0];

	pready_low_in_reset: assert property (@(posedge clk_i) !rst_n_i |-> !apb_rsp_i.pready)
		else $error("pready high while reset is asserted");

	fsm_in_access: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		first |-> state_i == BUS_ACCESS)
		else $error("bus state machine missed the setup cycle");

	read_one_wait: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		first && mem_rd |-> !apb_rsp_i.pready ##1 apb_rsp_i.pready)
		else $error("memory read did not complete in the second access cycle");

	other_no_wait: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		first && !mem_rd |-> apb_rsp_i.pready)
		else $error("access did not complete in the first access cycle");

	req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		access && !apb_rsp_i.pready |=> $stable(apb_req_i))
		else $error("request changed while pready was low");

	// full without not-empty means full and empty together.
	queue_flags: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		status_rd |-> (apb_rsp_i.prdata[1:0] != 2'b10))
		else $error("queue status shows full and empty at once");

endmodule

// File: ps2_idle_timer.sv
module ps2_idle_timer (
	input  logic clk_i,
	input  logic rst_n_i,
	input  logic fall_i,
	input  logic busy_i,
	output logic stall_o
);
	import soc_pkg::*;

	logic [$clog2(PS2_IDLE_CYCLES+1)-1:0] cnt;

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			cnt     <= '0;
			stall_o <= 1'b0;
		end else begin
			stall_o <= 1'b0;
			if (fall_i || !busy_i) begin
				cnt <= '0;
			end else if (int'(cnt) != PS2_IDLE_CYCLES) begin
				cnt     <= cnt + 1'b1;
				stall_o <= (int'(cnt) == PS2_IDLE_CYCLES - 1);	// once at the limit.
			end
		end
	end

endmodule

// File: ps2_receiver.sv
module ps2_receiver (
	input  logic       clk_i,
	input  logic       rst_n_i,
	input  logic       ps2_clk_i,
	input  logic       ps2_dat_i,
	input  logic       stall_i,
	output logic       fall_o,
	output logic       busy_o,
	output logic [7:0] byte_o,
	output logic       valid_o
);

	logic [2:0] clk_sync;	// two sync flops plus edge history.
	logic [1:0] dat_sync;
	logic       dat_bit;
	logic [3:0] bit_idx;	// 0 waits for start, 10 is the stop bit.
	logic [9:0] shreg;	// start, data, parity.
	logic       frame_ok;

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			clk_sync <= '1;
			dat_sync <= '1;
		end else begin
			clk_sync <= {clk_sync[1:0], ps2_clk_i};
			dat_sync <= {dat_sync[0], ps2_dat_i};
		end
	end

	assign fall_o  = clk_sync[2] && !clk_sync[1];
	assign dat_bit = dat_sync[1];
	assign busy_o  = (bit_idx != 4'd0);

	// odd parity over data and parity bit.
	assign frame_ok = !shreg[0] && dat_bit && (^shreg[9:1]);

	always_ff @(posedge clk_i) begin
		if (fall_o && (bit_idx != 4'd10)) begin
			shreg <= {dat_bit, shreg[9:1]};
		end
	end

	assign byte_o = shreg[8:1];

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			bit_idx <= 4'd0;
			valid_o <= 1'b0;
		end else begin
			valid_o <= 1'b0;
			if (stall_i) begin
				bit_idx <= 4'd0;	// abandon partial frame.
			end else if (fall_o) begin
				if (bit_idx == 4'd0) begin
					if (!dat_bit) begin
						bit_idx <= 4'd1;
					end
				end else if (bit_idx == 4'd10) begin
					bit_idx <= 4'd0;
					valid_o <= frame_ok;	// bad frames dropped.
				end else begin
					bit_idx <= bit_idx + 4'd1;
				end
			end
		end
	end

endmodule

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_nexys_soc -f vlog.f
./obj_dir/Vtb_nexys_soc > sim.log 2>&1 || echo "TEST RESULT: FAIL" >> sim.log
cat sim.log
if grep -q "TEST RESULT: FAIL" sim.log; then
	exit 1
fi
exit 0

// File: soc_pkg.sv
package soc_pkg;

	localparam int ADDR_W          = 15;	// byte address bits 15:1.
	localparam int DATA_W          = 16;
	localparam int STRB_W          = 2;
	localparam int MEM_WORDS       = 8192;
	localparam int MEM_ADDR_W      = 13;
	localparam int KBD_DEPTH       = 4;
	localparam int PS2_IDLE_CYCLES = 2000;	// stalled frame limit.

	localparam logic [15:0] PROG_BASE = 16'h0000;	// 0000-3fff.
	localparam logic [15:0] KBD_BASE  = 16'hB000;	// b000-bfff, registers repeat.
	localparam logic [15:0] VID_BASE  = 16'hC000;	// c000-ffff.

	localparam logic [1:0] PROG_TAG = PROG_BASE[15:14];
	localparam logic [3:0] KBD_TAG  = KBD_BASE[15:12];
	localparam logic [1:0] VID_TAG  = VID_BASE[15:14];

	typedef enum logic [1:0] {REG_PROG, REG_KBD, REG_VID, REG_NONE} region_e;

	typedef enum logic [1:0] {BUS_IDLE, BUS_ACCESS, BUS_READ_WAIT} bus_state_e;

	typedef struct packed {
		logic              psel;
		logic              penable;
		logic              pwrite;
		logic [ADDR_W-1:0] paddr;
		logic [DATA_W-1:0] pwdata;
		logic [STRB_W-1:0] pstrb;
	} apb_req_t;

	typedef struct packed {
		logic [DATA_W-1:0] prdata;
		logic              pready;
	} apb_rsp_t;

	typedef struct packed {
		logic                  en;
		logic                  we;
		logic [MEM_ADDR_W-1:0] addr;
		logic [DATA_W-1:0]     wdata;
		logic [STRB_W-1:0]     strb;
	} ram_req_t;

	typedef struct packed {
		logic rd;
		logic sel;	// address bit 1, status or data.
	} kbd_req_t;

endpackage

// File: tb_nexys_soc.sv
module tb_nexys_soc;
	import soc_pkg::*;

	localparam int CLK_PERIOD   = 8;
	localparam int PS2_HALF     = 20;	// system clocks per ps/2 half period.
	localparam int FRAME_CYCLES = 13 * 2 * PS2_HALF;
	localparam int N_XFERS      = 200;
	localparam int N_FRAMES     = 14;
	localparam int WATCHDOG     = 2 * CLK_PERIOD * (16 + N_XFERS * 6 + N_FRAMES * FRAME_CYCLES
		+ PS2_IDLE_CYCLES + 100);
	localparam logic [15:0] STATUS_ADDR = 16'hB000;
	localparam logic [15:0] DATA_ADDR   = 16'hB002;

	logic              clk_i;
	logic              rst_n_i;
	apb_req_t          apb_req;
	apb_rsp_t          apb_rsp;
	logic              ps2_clk;
	logic              ps2_dat;
	logic [DATA_W-1:0] ref_mem [int];	// word index to expected value.
	logic [31:0]       rng_state;
	string             test_name;
	int                errors;
	int                tests_run;
	int                tests_failed;
	int                start_errors;

	nexys_soc nexys_soc_inst (
		.clk_i    (clk_i),
		.rst_n_i  (rst_n_i),
		.apb_req_i(apb_req),
		.apb_rsp_o(apb_rsp),
		.ps2_clk_i(ps2_clk),
		.ps2_dat_i(ps2_dat)
	);

	bind nexys_soc nexys_soc_chk chk_inst (
		.clk_i(clk_i), .rst_n_i(rst_n_i), .apb_req_i(apb_req_i), .apb_rsp_i(apb_rsp_o),
		.state_i(bus.state_q), .region_i(bus.region)
	);

	initial begin
		clk_i = 1'b0;
		forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
	end

	initial begin
		#(WATCHDOG);
		$display("watchdog expired before the tests finished");
		$display("TEST RESULT: FAIL");
		$finish;
	end

	function logic [31:0] next_random();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	task automatic wait_clocks(input int n);
		repeat (n) @(posedge clk_i);
	endtask

	task automatic apb_xfer(input logic wr, input logic [15:0] addr, input logic [15:0] wdata,
			input logic [1:0] strb, output logic [15:0] rdata);
		@(posedge clk_i);
		apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr[15:1],
			pwdata: wdata, pstrb: strb};
		@(posedge clk_i);
		apb_req.penable <= 1'b1;
		@(negedge clk_i);
		while (!apb_rsp.pready) @(negedge clk_i);
		rdata = apb_rsp.prdata;	// stable at mid cycle.
		@(posedge clk_i);
		apb_req.psel    <= 1'b0;
		apb_req.penable <= 1'b0;
	endtask

	task automatic check_eq(input logic [15:0] expected, input logic [15:0] actual);
		assert (actual === expected) else begin
			$display("** Error %s: expected %h, actual %h", test_name, expected, actual);
			errors++;
		end
	endtask

	task automatic mem_write(input logic [15:0] addr, input logic [15:0] data,
			input logic [1:0] strb);
		logic [15:0] dummy;
		logic [15:0] word;
		apb_xfer(1'b1, addr, data, strb, dummy);
		if (addr < 16'h4000 || addr >= 16'hC000) begin	// mapped memories only.
			word = ref_mem.exists(int'(addr[15:1])) ? ref_mem[int'(addr[15:1])] : 'x;
			if (strb[0]) word[7:0] = data[7:0];
			if (strb[1]) word[15:8] = data[15:8];
			ref_mem[int'(addr[15:1])] = word;
		end
	endtask

	task automatic read_expect(input logic [15:0] addr, input logic [15:0] expected);
		logic [15:0] rd;
		apb_xfer(1'b0, addr, 16'h0000, 2'b00, rd);
		check_eq(expected, rd);
	endtask

	task automatic verify_all();
		foreach (ref_mem[w]) read_expect(16'(w * 2), ref_mem[w]);
	endtask

	task automatic ps2_send(input logic [7:0] data, input logic bad_parity, input logic bad_stop,
			input int nbits);
		logic [10:0] frame;
		frame = {~bad_stop, ~(^data) ^ bad_parity, data, 1'b0};	// lsb goes first.
		for (int i = 0; i < nbits; i++) begin
			@(posedge clk_i);
			ps2_dat <= frame[i];
			wait_clocks(PS2_HALF);
			ps2_clk <= 1'b0;
			wait_clocks(PS2_HALF);
			ps2_clk <= 1'b1;
		end
		@(posedge clk_i);
		ps2_dat <= 1'b1;
		wait_clocks(2 * PS2_HALF);
	endtask

	task automatic begin_test(input string name);
		test_name    = name;
		start_errors = errors;
	endtask

	task automatic end_test();
		tests_run++;
		if (errors == start_errors) begin
			$display("test %s passed", test_name);
		end else begin
			tests_failed++;
			$display("test %s failed with %0d errors", test_name, errors - start_errors);
		end
	endtask

	initial begin
		logic [31:0] r;
		logic [15:0] addrs [16];
		logic [12:0] offs [8];
		logic [7:0]  keys [6];
		apb_req   <= '0;
		ps2_clk   <= 1'b1;
		ps2_dat   <= 1'b1;
		rst_n_i   <= 1'b0;
		rng_state = 32'h5dc3;
		errors    = 0;
		tests_run = 0;
		tests_failed = 0;
		wait_clocks(16);
		rst_n_i <= 1'b1;

		begin_test("prog_mem_strobes");
		for (int i = 0; i < 16; i++) begin
			r = next_random();
			addrs[i] = {2'b00, r[13:1], 1'b0};
			mem_write(addrs[i], r[31:16], 2'b11);
		end
		for (int i = 0; i < 16; i++) begin
			r = next_random();
			mem_write(addrs[i], r[15:0], r[17:16]);	// random lanes.
		end
		for (int i = 0; i < 16; i++) read_expect(addrs[i], ref_mem[int'(addrs[i][15:1])]);
		end_test();

		begin_test("vid_separate");
		for (int k = 0; k < 8; k++) begin
			r = next_random();
			offs[k] = 13'(k * 1031 + 5);
			mem_write({2'b00, offs[k], 1'b0}, r[15:0], 2'b11);
			mem_write({2'b11, offs[k], 1'b0}, ~r[15:0], 2'b11);
		end
		for (int k = 0; k < 8; k++) begin
			read_expect({2'b00, offs[k], 1'b0}, ref_mem[int'({2'b00, offs[k]})]);
			read_expect({2'b11, offs[k], 1'b0}, ref_mem[int'({2'b11, offs[k]})]);
		end
		end_test();

		begin_test("unmapped");
		read_expect(16'h4000, 16'h0000);
		read_expect(16'h7FFE, 16'h0000);
		read_expect(16'h8000, 16'h0000);
		read_expect(16'hAFFE, 16'h0000);
		for (int k = 0; k < 4; k++) begin
			mem_write({2'b01, offs[k], 1'b0}, 16'hDEAD, 2'b11);
			mem_write({4'h8, offs[k][10:0], 1'b0}, 16'hBEEF, 2'b11);
		end
		verify_all();
		end_test();

		begin_test("kbd_receive");
		for (int i = 0; i < 3; i++) begin
			r = next_random();
			keys[i] = r[7:0];
			ps2_send(keys[i], 1'b0, 1'b0, 11);
		end
		read_expect(STATUS_ADDR, 16'h0001);
		for (int i = 0; i < 3; i++) read_expect(DATA_ADDR, {8'h00, keys[i]});
		read_expect(STATUS_ADDR, 16'h0000);
		read_expect(DATA_ADDR, 16'h0000);
		end_test();

		begin_test("kbd_errors");
		ps2_send(8'h3C, 1'b1, 1'b0, 11);
		ps2_send(8'hA5, 1'b0, 1'b1, 11);
		read_expect(STATUS_ADDR, 16'h0000);
		for (int i = 0; i < 6; i++) begin
			r = next_random();
			keys[i] = r[7:0];
			ps2_send(keys[i], 1'b0, 1'b0, 11);
		end
		read_expect(STATUS_ADDR, 16'h0003);
		for (int i = 0; i < 4; i++) read_expect(DATA_ADDR, {8'h00, keys[i]});
		read_expect(STATUS_ADDR, 16'h0000);
		ps2_send(8'h5A, 1'b0, 1'b0, 5);	// start plus four data bits.
		wait_clocks(PS2_IDLE_CYCLES + 100);
		read_expect(STATUS_ADDR, 16'h0000);
		ps2_send(8'h1D, 1'b0, 1'b0, 11);
		read_expect(STATUS_ADDR, 16'h0001);
		read_expect(DATA_ADDR, 16'h001D);
		read_expect(STATUS_ADDR, 16'h0000);
		end_test();

		begin_test("kbd_alias");
		ps2_send(8'h72, 1'b0, 1'b0, 11);
		read_expect(STATUS_ADDR, 16'h0001);
		read_expect(16'hB004, 16'h0001);
		read_expect(16'hBFF8, 16'h0001);
		read_expect(16'hB006, 16'h0072);
		read_expect(16'hB004, 16'h0000);
		end_test();

		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// File: vlog.f
soc_pkg.sv
word_ram.sv
ps2_idle_timer.sv
ps2_receiver.sv
kbd_queue.sv
bus_ctrl.sv
nexys_soc.sv
nexys_soc_chk.sv
tb_nexys_soc.sv

// File: word_ram.sv
module word_ram #(
	parameter int WORDS = soc_pkg::MEM_WORDS
) (
	input  logic                       clk_i,
	input  soc_pkg::ram_req_t          req_i,
	output logic [soc_pkg::DATA_W-1:0] rdata_o
);
	import soc_pkg::*;

	logic [DATA_W-1:0] mem [WORDS];

	// byte lane writes.
	always_ff @(posedge clk_i) begin
		if (req_i.en && req_i.we) begin
			for (int i = 0; i < STRB_W; i++) begin
				if (req_i.strb[i]) begin
					mem[req_i.addr][i*(DATA_W/STRB_W) +: DATA_W/STRB_W] <=
						req_i.wdata[i*(DATA_W/STRB_W) +: DATA_W/STRB_W];
				end
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (req_i.en && !req_i.we) begin
			rdata_o <= mem[req_i.addr];	// one cycle read.
		end
	end

endmodule
